//--- list.f
src/fpir_pkg.sv
src/fpir_sig_select.sv
src/fpir_sig_mult_pipe.sv
src/fpir_sig_mult_iter.sv
src/fpir_exp_unit.sv
src/fpir_mul_ctrl.sv
src/fpir_mul_unit.sv
sim/tb_fpir_mul_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then judge the run from its log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_fpir_mul_unit -f list.f -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1
grep -qx "Simulation finished: PASS" sim.log && echo "simulation passed" && exit 0 || {
  echo "simulation failed, see sim.log"
  exit 1
}

//--- sim/tb_fpir_mul_unit.sv
`timescale 1ns/100ps

module tb_fpir_mul_unit;

  import fpir_pkg::*;

  localparam int N_RANDOM = 200;
  localparam int N_SAT = 6;
  localparam int N_SPECIAL = 16;
  // Random set and saturation on both paths plus class pairs and one held req
  localparam int N_OPS = 2 * N_RANDOM + 2 * N_SAT + N_SPECIAL + 1;
  localparam int WATCHDOG_CYCLES = N_OPS * (ITER_CYCLES + 8) + 50;
  localparam int PIPE_ACK_CYCLES = 5;
  localparam int ITER_ACK_CYCLES = ITER_CYCLES + 3;
  localparam int HOLD_CYCLES = 20;

  logic                     clk = 1'b0;
  logic                     rst;
  logic [BW_FPIR_VALUE-1:0] op_a;
  logic [BW_FPIR_VALUE-1:0] op_b;
  logic                     use_iter;
  logic                     req;
  logic [BW_FPIR_VALUE-1:0] result;
  logic                     ack;

  int                       seed;
  logic [BW_FPIR_VALUE-1:0] exp_result;
  logic                     cur_iter;
  logic [BW_FPIR_VALUE-1:0] result_prev;
  int                       req_edges;
  int                       ack_edges_exp;
  logic [BW_FPIR_VALUE-1:0] rand_a [N_RANDOM];
  logic [BW_FPIR_VALUE-1:0] rand_b [N_RANDOM];
  // Exponent pairs around both saturation limits
  int sat_exp_a [N_SAT] = '{400, 511, -400, -512, 255, -256};
  int sat_exp_b [N_SAT] = '{400, 511, -300, -512, 256, -256};

  fpir_mul_unit UUT (
    .clk      (clk),
    .rst      (rst),
    .op_a     (op_a),
    .op_b     (op_b),
    .use_iter (use_iter),
    .req      (req),
    .result   (result),
    .ack      (ack)
  );

  always #5 clk = ~clk;

  // Count of rising edges that see req high including the edge raising ack
  always @(posedge clk) begin
    if (!req) begin
      req_edges <= 0;
    end else begin
      req_edges <= req_edges + 1;
    end
    result_prev <= result;
  end

  assign ack_edges_exp = (cur_iter ? ITER_ACK_CYCLES : PIPE_ACK_CYCLES) + 1;

  // ****************************************
  // Failure reporting
  // ****************************************
  task automatic report_mismatch(input string name, input logic [BW_FPIR_VALUE-1:0] expected,
                                 input logic [BW_FPIR_VALUE-1:0] actual);
    $display("[ERROR] %0t %s: expected %0h, got %0h", $time, name, expected, actual);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic abort_run(input string what);
    $display("[ERROR] %0t %s", $time, what);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // ****************************************
  // Checks sampled mid-cycle
  // ****************************************
  a_reset_ack: assert property (@(negedge clk) rst |-> !ack)
    else report_mismatch("ack", '0, BW_FPIR_VALUE'(ack));
  a_reset_result: assert property (@(negedge clk) rst |-> (result == '0))
    else report_mismatch("result", '0, result);
  // No ack out of an idle unit
  a_idle_quiet: assert property (@(negedge clk) disable iff (rst)
      (!req && !$past(req) && !$past(ack)) |-> !ack)
    else report_mismatch("ack", '0, BW_FPIR_VALUE'(ack));
  // Back-pressure holds ack and result
  a_ack_held: assert property (@(negedge clk) disable iff (rst)
      ($past(ack) && $past(req)) |-> ack)
    else report_mismatch("ack", BW_FPIR_VALUE'(1), BW_FPIR_VALUE'(ack));
  a_result_stable: assert property (@(negedge clk) disable iff (rst)
      ($past(ack) && ack) |-> (result == result_prev))
    else report_mismatch("result", result_prev, result);
  a_ack_release: assert property (@(negedge clk) disable iff (rst)
      $fell(ack) |-> !$past(req))
    else abort_run("ack dropped while req was still high");
  a_result_value: assert property (@(negedge clk) disable iff (rst)
      $rose(ack) |-> (result == exp_result))
    else report_mismatch("result", exp_result, result);
  a_ack_latency: assert property (@(negedge clk) disable iff (rst)
      $rose(ack) |-> (req_edges == ack_edges_exp))
    else report_mismatch("req edges to ack", BW_FPIR_VALUE'(ack_edges_exp),
                         BW_FPIR_VALUE'(req_edges));

  // ****************************************
  // Reference model
  // ****************************************
  task automatic compute_expected(input logic [BW_FPIR_VALUE-1:0] a,
                                  input logic [BW_FPIR_VALUE-1:0] b,
                                  output logic [BW_FPIR_VALUE-1:0] res);
    logic [1:0]        ca;
    logic [1:0]        cb;
    logic [1:0]        cr;
    logic              sa;
    logic              sb;
    logic signed [9:0] exa;
    logic signed [9:0] exb;
    logic [12:0]       xa;
    logic [12:0]       xb;
    logic [25:0]       prod;
    logic [12:0]       win;
    logic              nrm;
    logic              ovf;
    int                es;
    // Operand overflow bit plays no part in a product
    {ca, sa, exa, xa} = a[BW_FPIR_VALUE-1:BW_OVERFLOW];
    {cb, sb, exb, xb} = b[BW_FPIR_VALUE-1:BW_OVERFLOW];
    // NaN has priority and 0 * inf counts as NaN
    if (ca == FPIR_NAN || cb == FPIR_NAN || (ca == FPIR_ZERO && cb == FPIR_INF)
        || (ca == FPIR_INF && cb == FPIR_ZERO)) begin
      cr = FPIR_NAN;
    end else if (ca == FPIR_INF || cb == FPIR_INF) begin
      cr = FPIR_INF;
    end else if (ca == FPIR_ZERO || cb == FPIR_ZERO) begin
      cr = FPIR_ZERO;
    end else begin
      cr = FPIR_NORMAL;
    end
    // Full product then the 13-bit window under the leading one
    prod = 26'(xa) * 26'(xb);
    nrm = prod[25];
    win = nrm ? prod[25:13] : prod[24:12];
    es = int'(exa) + int'(exb) + int'(nrm);
    ovf = 1'b0;
    if (es > 511) begin
      es = 511;
      ovf = 1'b1;
    end else if (es < -512) begin
      es = -512;
      ovf = 1'b1;
    end
    if (cr == FPIR_NORMAL) begin
      res = {cr, sa ^ sb, BW_EXPONENT'(es), win, ovf};
    end else begin
      res = {cr, sa ^ sb, 24'b0};
    end
  endtask

  // ****************************************
  // Stimulus helpers
  // ****************************************
  // Leading one set with fraction, guard and sign from the generator
  function automatic logic [BW_FPIR_VALUE-1:0] make_operand(input logic [1:0] cls,
                                                            input int expv);
    logic [31:0] rnd;
    rnd = $random(seed);
    return {cls, rnd[31], BW_EXPONENT'(expv), 1'b1, rnd[9:0], rnd[11:10], 1'b0};
  endfunction

  function automatic int small_exp();
    return $random(seed) % 101;
  endfunction

  task automatic next_drive_slot();
    @(posedge clk);
    #1;
  endtask

  // One full four-phase transfer with req kept high for hold extra cycles
  task automatic run_op(input logic [BW_FPIR_VALUE-1:0] a, input logic [BW_FPIR_VALUE-1:0] b,
                        input logic iter, input int hold);
    next_drive_slot();
    compute_expected(a, b, exp_result);
    cur_iter = iter;
    op_a = a;
    op_b = b;
    use_iter = iter;
    req = 1'b1;
    do begin
      next_drive_slot();
    end while (!ack);
    repeat (hold) next_drive_slot();
    req = 1'b0;
    do begin
      next_drive_slot();
    end while (ack);
  endtask

  // ****************************************
  // Main sequence and watchdog
  // ****************************************
  initial begin
    logic [BW_FPIR_VALUE-1:0] a_op;
    logic [BW_FPIR_VALUE-1:0] b_op;
    seed = 32'h80fe3839;
    rst = 1'b1;
    op_a = '0;
    op_b = '0;
    use_iter = 1'b0;
    req = 1'b0;
    exp_result = '0;
    cur_iter = 1'b0;
    for (int i = 0; i < N_RANDOM; i++) begin
      rand_a[i] = make_operand(FPIR_NORMAL, small_exp());
      rand_b[i] = make_operand(FPIR_NORMAL, small_exp());
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // Quiet gap with req low
    repeat (4) next_drive_slot();
    for (int i = 0; i < N_RANDOM; i++) begin
      run_op(rand_a[i], rand_b[i], 1'b0, 0);
    end
    // Same operands through the shift-add path
    for (int i = 0; i < N_RANDOM; i++) begin
      run_op(rand_a[i], rand_b[i], 1'b1, 0);
    end
    for (int i = 0; i < N_SAT; i++) begin
      a_op = make_operand(FPIR_NORMAL, sat_exp_a[i]);
      b_op = make_operand(FPIR_NORMAL, sat_exp_b[i]);
      run_op(a_op, b_op, 1'b0, 0);
      run_op(a_op, b_op, 1'b1, 0);
    end
    // Every class pair with alternating paths
    for (int ca = 0; ca < 4; ca++) begin
      for (int cb = 0; cb < 4; cb++) begin
        a_op = make_operand(2'(ca), small_exp());
        b_op = make_operand(2'(cb), small_exp());
        run_op(a_op, b_op, 1'((ca + cb) % 2), 0);
      end
    end
    // Long back-pressure
    run_op(rand_a[0], rand_b[0], 1'b0, HOLD_CYCLES);
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run("watchdog expired before all operations completed");
  end

endmodule

//--- src/fpir_exp_unit.sv
`timescale 1ns/100ps

module fpir_exp_unit (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           capture,
  input  logic                                           sign,
  input  logic                                           norm,
  input  logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_norm,
  input  logic [fpir_pkg::BW_FPIR_TYPE-1:0]              class_a,
  input  logic [fpir_pkg::BW_FPIR_TYPE-1:0]              class_b,
  input  logic [fpir_pkg::BW_EXPONENT-1:0]               exp_a,
  input  logic [fpir_pkg::BW_EXPONENT-1:0]               exp_b,
  output logic [fpir_pkg::BW_FPIR_VALUE-1:0]             result
);

  import fpir_pkg::*;

  logic signed [BW_EXPONENT:0]   exp_sum;
  logic [BW_EXPONENT-1:0]        exp_sat;
  logic [BW_OVERFLOW-1:0]        ovf;
  logic                          any_nan;
  logic                          any_inf;
  logic                          any_zero;
  logic                          zero_times_inf;
  logic [BW_FPIR_TYPE-1:0]       class_res;
  logic [BW_FPIR_VALUE-1:0]      result_d;

  // ****************************************
  // Exponent with saturation
  // ****************************************
  // One extra bit covers 511+511+1 and -1024
  assign exp_sum = $signed({exp_a[BW_EXPONENT-1], exp_a})
                 + $signed({exp_b[BW_EXPONENT-1], exp_b})
                 + $signed({{BW_EXPONENT{1'b0}}, norm});

  always_comb begin
    exp_sat = exp_sum[BW_EXPONENT-1:0];
    ovf = '0;
    if (exp_sum > (BW_EXPONENT+1)'(EXP_MAX)) begin
      exp_sat = EXP_MAX;
      ovf = '1;
    end else if (exp_sum < (BW_EXPONENT+1)'(EXP_MIN)) begin
      exp_sat = EXP_MIN;
      ovf = '1;
    end
  end

  // ****************************************
  // Class resolution
  // ****************************************
  assign any_nan = (class_a == FPIR_NAN) || (class_b == FPIR_NAN);
  assign any_inf = (class_a == FPIR_INF) || (class_b == FPIR_INF);
  assign any_zero = (class_a == FPIR_ZERO) || (class_b == FPIR_ZERO);
  // 0 * inf is undefined
  assign zero_times_inf = any_zero && any_inf;

  always_comb begin
    if (any_nan || zero_times_inf) begin
      class_res = FPIR_NAN;
    end else if (any_inf) begin
      class_res = FPIR_INF;
    end else if (any_zero) begin
      class_res = FPIR_ZERO;
    end else begin
      class_res = FPIR_NORMAL;
    end
  end

  // Specials keep only class and sign
  always_comb begin
    if (class_res == FPIR_NORMAL) begin
      result_d = {class_res, sign, exp_sat, sig_norm, ovf};
    end else begin
      result_d = {class_res, sign, {(BW_FPIR_VALUE-BW_FPIR_TYPE-1){1'b0}}};
    end
  end

  // Result held until the next capture
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (capture) begin
      result <= result_d;
    end
  end

endmodule

//--- src/fpir_mul_ctrl.sv
`timescale 1ns/100ps

module fpir_mul_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic req,
  input  logic use_iter,
  input  logic iter_done,
  output logic load,
  output logic start,
  output logic capture,
  output logic ack
);

  import fpir_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD,
    S_RUN,
    S_CAPTURE,
    S_ACK,
    S_RELEASE
  } state_t;

  state_t                   state_q;
  state_t                   state_d;
  logic                     path_iter_q;
  logic [BW_ITER_COUNT-1:0] run_cnt_q;
  logic                     start_q;
  logic                     pipe_done;
  logic                     wait_done;

  // ****************************************
  // Product wait
  // ****************************************
  // Cycles since start, zero in the start cycle
  assign pipe_done = (run_cnt_q == BW_ITER_COUNT'(PIPE_LATENCY));
  assign wait_done = path_iter_q ? iter_done : pipe_done;

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE:    if (req) state_d = S_LOAD;
      S_LOAD:    state_d = S_RUN;
      S_RUN:     if (wait_done) state_d = S_CAPTURE;
      S_CAPTURE: state_d = S_ACK;
      // Ack held for as long as req stays high
      S_ACK:     if (!req) state_d = S_RELEASE;
      S_RELEASE: state_d = S_IDLE;
      default:   state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
      path_iter_q <= 1'b0;
      run_cnt_q <= '0;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // start follows load by one cycle
      start_q <= (state_q == S_LOAD);
      if (state_q == S_IDLE && req) begin
        path_iter_q <= use_iter;
      end
      if (state_q == S_LOAD) begin
        run_cnt_q <= '0;
      end else if (state_q == S_RUN) begin
        run_cnt_q <= run_cnt_q + 1'b1;
      end
    end
  end

  // Strobes decoded from state
  assign load = (state_q == S_LOAD);
  assign start = start_q;
  assign capture = (state_q == S_CAPTURE);
  assign ack = (state_q == S_ACK) || (state_q == S_RELEASE);

endmodule

//--- src/fpir_mul_unit.sv
`timescale 1ns/100ps

module fpir_mul_unit (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [fpir_pkg::BW_FPIR_VALUE-1:0]  op_a,
  input  logic [fpir_pkg::BW_FPIR_VALUE-1:0]  op_b,
  input  logic                                use_iter,
  input  logic                                req,
  output logic [fpir_pkg::BW_FPIR_VALUE-1:0]  result,
  output logic                                ack
);

  import fpir_pkg::*;

  // Sequencer strobes
  logic                               load;
  logic                               start;
  logic                               capture;
  logic                               iter_done;

  // Significand datapath
  logic [BW_SIGNIFICAND_EXTENDED-1:0] sig_a;
  logic [BW_SIGNIFICAND_EXTENDED-1:0] sig_b;
  logic [BW_PRODUCT-1:0]              pipe_product;
  logic [BW_PRODUCT-1:0]              iter_product;
  logic                               sign;
  logic                               norm;
  logic [BW_SIGNIFICAND_EXTENDED-1:0] sig_norm;

  // Registered operand fields
  logic [BW_FPIR_TYPE-1:0]            class_a;
  logic [BW_FPIR_TYPE-1:0]            class_b;
  logic [BW_EXPONENT-1:0]             exp_a;
  logic [BW_EXPONENT-1:0]             exp_b;

  // ****************************************
  // Control
  // ****************************************
  fpir_mul_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .use_iter  (use_iter),
    .iter_done (iter_done),
    .load      (load),
    .start     (start),
    .capture   (capture),
    .ack       (ack)
  );

  // ****************************************
  // Datapath
  // ****************************************
  fpir_sig_select u_sig_select (
    .clk          (clk),
    .rst          (rst),
    .load         (load),
    .use_iter     (use_iter),
    .op_a         (op_a),
    .op_b         (op_b),
    .pipe_product (pipe_product),
    .iter_product (iter_product),
    .sig_a        (sig_a),
    .sig_b        (sig_b),
    .sign         (sign),
    .norm         (norm),
    .sig_norm     (sig_norm),
    .class_a      (class_a),
    .class_b      (class_b),
    .exp_a        (exp_a),
    .exp_b        (exp_b)
  );

  // Both product sources start together
  fpir_sig_mult_pipe u_mult_pipe (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .sig_a   (sig_a),
    .sig_b   (sig_b),
    .product (pipe_product)
  );

  fpir_sig_mult_iter u_mult_iter (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .sig_a   (sig_a),
    .sig_b   (sig_b),
    .product (iter_product),
    .done    (iter_done)
  );

  fpir_exp_unit u_exp_unit (
    .clk      (clk),
    .rst      (rst),
    .capture  (capture),
    .sign     (sign),
    .norm     (norm),
    .sig_norm (sig_norm),
    .class_a  (class_a),
    .class_b  (class_b),
    .exp_a    (exp_a),
    .exp_b    (exp_b),
    .result   (result)
  );

endmodule

//--- src/fpir_pkg.sv
package fpir_pkg;

  // ****************************************
  // FPIR field widths
  // ****************************************
  localparam int BW_FPIR_TYPE = 2;
  localparam int BW_EXPONENT = 10;
  // Significand carries its leading one
  localparam int BW_SIGNIFICAND = 11;
  localparam int BW_GUARD = 2;
  localparam int BW_OVERFLOW = 1;
  localparam int BW_SIGNIFICAND_EXTENDED = BW_SIGNIFICAND + BW_GUARD;
  // Full double-width product, no resize
  localparam int BW_PRODUCT = 2 * BW_SIGNIFICAND_EXTENDED;
  localparam int BW_FPIR_VALUE = BW_FPIR_TYPE + 1 + BW_EXPONENT
                               + BW_SIGNIFICAND_EXTENDED + BW_OVERFLOW;

  // Field LSB positions, packed from the top bit down
  // as class, sign, exponent, significand, guard, overflow
  localparam int POS_GUARD = BW_OVERFLOW;
  localparam int POS_SIGNIFICAND = POS_GUARD + BW_GUARD;
  localparam int POS_EXPONENT = POS_SIGNIFICAND + BW_SIGNIFICAND;
  localparam int POS_SIGN = POS_EXPONENT + BW_EXPONENT;
  localparam int POS_FPIR_TYPE = POS_SIGN + 1;

  // ****************************************
  // Class codes
  // ****************************************
  localparam logic [BW_FPIR_TYPE-1:0] FPIR_ZERO = 2'd0;
  localparam logic [BW_FPIR_TYPE-1:0] FPIR_NORMAL = 2'd1;
  localparam logic [BW_FPIR_TYPE-1:0] FPIR_INF = 2'd2;
  localparam logic [BW_FPIR_TYPE-1:0] FPIR_NAN = 2'd3;

  // Signed exponent limits, 511 and -512
  localparam logic signed [BW_EXPONENT-1:0] EXP_MAX = {1'b0, {(BW_EXPONENT-1){1'b1}}};
  localparam logic signed [BW_EXPONENT-1:0] EXP_MIN = {1'b1, {(BW_EXPONENT-1){1'b0}}};

  // ****************************************
  // Multiplier timing and split
  // ****************************************
  // One multiplier bit per cycle
  localparam int ITER_CYCLES = BW_SIGNIFICAND_EXTENDED;
  localparam int BW_ITER_COUNT = $clog2(ITER_CYCLES + 1);
  localparam int PIPE_LATENCY = 2;
  // Halves of the multiplier operand in the pipelined path
  localparam int BW_SPLIT_LO = BW_SIGNIFICAND_EXTENDED / 2;
  localparam int BW_SPLIT_HI = BW_SIGNIFICAND_EXTENDED - BW_SPLIT_LO;

endpackage

//--- src/fpir_sig_mult_iter.sv
`timescale 1ns/100ps

module fpir_sig_mult_iter (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           start,
  input  logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_a,
  input  logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_b,
  output logic [fpir_pkg::BW_PRODUCT-1:0]                product,
  output logic                                           done
);

  import fpir_pkg::*;

  // Shift-add datapath
  logic [BW_PRODUCT-1:0]              mcand_q;
  logic [BW_SIGNIFICAND_EXTENDED-1:0] mplier_q;
  logic [BW_PRODUCT-1:0]              acc_q;
  // Step control
  logic [BW_ITER_COUNT-1:0]           step_q;
  logic                               busy_q;
  logic                               done_q;

  logic [BW_PRODUCT-1:0]              mcand_cur;
  logic [BW_SIGNIFICAND_EXTENDED-1:0] mplier_cur;
  logic [BW_PRODUCT-1:0]              acc_cur;
  logic [BW_ITER_COUNT-1:0]           step_cur;
  logic [BW_PRODUCT-1:0]              acc_next;
  logic                               last_step;

  // ****************************************
  // Step operands
  // ****************************************
  // Start seeds fresh operands and a zero accumulator
  // A restart abandons any operation in flight
  assign mcand_cur = start ? BW_PRODUCT'(sig_a) : mcand_q;
  assign mplier_cur = start ? sig_b : mplier_q;
  assign acc_cur = start ? '0 : acc_q;
  assign step_cur = start ? '0 : step_q;

  // Add shifted multiplicand when the current LSB is set
  assign acc_next = acc_cur + (mplier_cur[0] ? mcand_cur : '0);
  assign last_step = (step_cur == BW_ITER_COUNT'(ITER_CYCLES - 1));

  // ****************************************
  // Control
  // ****************************************
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else begin
      // Single-cycle done pulse
      done_q <= 1'b0;
      if (start || busy_q) begin
        busy_q <= !last_step;
        done_q <= last_step;
        step_q <= step_cur + 1'b1;
      end
    end
  end

  // Accumulator holds the product once idle
  always_ff @(posedge clk) begin
    if (start || busy_q) begin
      acc_q <= acc_next;
      mcand_q <= mcand_cur << 1;
      mplier_q <= mplier_cur >> 1;
    end
  end

  assign product = acc_q;
  assign done = done_q;

endmodule

//--- src/fpir_sig_mult_pipe.sv
`timescale 1ns/100ps

module fpir_sig_mult_pipe (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           start,
  input  logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_a,
  input  logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_b,
  output logic [fpir_pkg::BW_PRODUCT-1:0]                product
);

  import fpir_pkg::*;

  localparam int BW_PP_LO = BW_SIGNIFICAND_EXTENDED + BW_SPLIT_LO;
  localparam int BW_PP_HI = BW_SIGNIFICAND_EXTENDED + BW_SPLIT_HI;

  logic [BW_PP_LO-1:0]   pp_lo_d;
  logic [BW_PP_HI-1:0]   pp_hi_d;
  logic [BW_PP_LO-1:0]   pp_lo_q;
  logic [BW_PP_HI-1:0]   pp_hi_q;
  logic                  stage1_vld;
  logic [BW_PRODUCT-1:0] sum_d;

  // ****************************************
  // Stage one, partial products
  // ****************************************
  // Multiplier split into low and high halves
  assign pp_lo_d = BW_PP_LO'(sig_a) * BW_PP_LO'(sig_b[BW_SPLIT_LO-1:0]);
  assign pp_hi_d = BW_PP_HI'(sig_a) * BW_PP_HI'(sig_b[BW_SIGNIFICAND_EXTENDED-1:BW_SPLIT_LO]);

  always_ff @(posedge clk) begin
    if (rst) begin
      stage1_vld <= 1'b0;
    end else begin
      stage1_vld <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      pp_lo_q <= pp_lo_d;
      pp_hi_q <= pp_hi_d;
    end
  end

  // ****************************************
  // Stage two, shifted sum
  // ****************************************
  // High half weighs 2^BW_SPLIT_LO
  assign sum_d = BW_PRODUCT'({pp_hi_q, {BW_SPLIT_LO{1'b0}}}) + BW_PRODUCT'(pp_lo_q);

  // Held between operations
  always_ff @(posedge clk) begin
    if (stage1_vld) begin
      product <= sum_d;
    end
  end

endmodule

//--- src/fpir_sig_select.sv
`timescale 1ns/100ps

module fpir_sig_select (
  input  logic                                           clk,
  input  logic                                           rst,
  input  logic                                           load,
  input  logic                                           use_iter,
  input  logic [fpir_pkg::BW_FPIR_VALUE-1:0]             op_a,
  input  logic [fpir_pkg::BW_FPIR_VALUE-1:0]             op_b,
  input  logic [fpir_pkg::BW_PRODUCT-1:0]                pipe_product,
  input  logic [fpir_pkg::BW_PRODUCT-1:0]                iter_product,
  output logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_a,
  output logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_b,
  output logic                                           sign,
  output logic                                           norm,
  output logic [fpir_pkg::BW_SIGNIFICAND_EXTENDED-1:0]   sig_norm,
  output logic [fpir_pkg::BW_FPIR_TYPE-1:0]              class_a,
  output logic [fpir_pkg::BW_FPIR_TYPE-1:0]              class_b,
  output logic [fpir_pkg::BW_EXPONENT-1:0]               exp_a,
  output logic [fpir_pkg::BW_EXPONENT-1:0]               exp_b
);

  import fpir_pkg::*;

  logic [BW_FPIR_VALUE-1:0] op_a_q;
  logic [BW_FPIR_VALUE-1:0] op_b_q;
  logic                     sel_iter_q;
  logic [BW_PRODUCT-1:0]    product_sel;

  // ****************************************
  // Operand capture
  // ****************************************
  // Path select is control state
  always_ff @(posedge clk) begin
    if (rst) begin
      sel_iter_q <= 1'b0;
    end else if (load) begin
      sel_iter_q <= use_iter;
    end
  end

  // Operands held until the next load
  always_ff @(posedge clk) begin
    if (load) begin
      op_a_q <= op_a;
      op_b_q <= op_b;
    end
  end

  // Field unpack
  assign class_a = op_a_q[POS_FPIR_TYPE +: BW_FPIR_TYPE];
  assign class_b = op_b_q[POS_FPIR_TYPE +: BW_FPIR_TYPE];
  assign exp_a = op_a_q[POS_EXPONENT +: BW_EXPONENT];
  assign exp_b = op_b_q[POS_EXPONENT +: BW_EXPONENT];

  // Significand with guard bits, always extended
  assign sig_a = op_a_q[POS_GUARD +: BW_SIGNIFICAND_EXTENDED];
  assign sig_b = op_b_q[POS_GUARD +: BW_SIGNIFICAND_EXTENDED];

  assign sign = op_a_q[POS_SIGN] ^ op_b_q[POS_SIGN];

  // ****************************************
  // Product select and normalize
  // ****************************************
  assign product_sel = sel_iter_q ? iter_product : pipe_product;

  // Product of two 1.x values lies in [1,4)
  assign norm = product_sel[BW_PRODUCT-1];

  // Upper window, low bits dropped without rounding
  assign sig_norm = norm ? product_sel[BW_PRODUCT-1 -: BW_SIGNIFICAND_EXTENDED]
                         : product_sel[BW_PRODUCT-2 -: BW_SIGNIFICAND_EXTENDED];

endmodule
